/* hw/vdp_reg_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// VDP register map, control register fields and copper instruction format.
// Blocks refer to these by scoped names, for example vdp_reg_pkg::reg_data_t.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package vdp_reg_pkg;

    localparam int REG_COUNT = 32;

    typedef logic [4:0]  reg_addr_t;
    typedef logic [15:0] reg_data_t;
    typedef logic [13:0] line_t;

    // Register map, every address not listed here is plain storage
    localparam reg_addr_t REG_CONTROL  = 5'd0;
    localparam reg_addr_t REG_SCROLL_X = 5'd1;
    localparam reg_addr_t REG_SCROLL_Y = 5'd2;

    // REG_CONTROL view, copper_enable sits in bit 0
    typedef struct packed {
        logic [14:0] spare;
        logic        copper_enable;
    } control_t;

    typedef enum logic [1:0] {
        COP_WAIT  = 2'd0,
        COP_WRITE = 2'd1,
        COP_END   = 2'd2
    } cop_op_t;

    typedef struct packed {
        cop_op_t op;
        line_t   target_line;
    } cop_wait_t;

    // Immediate is 9 bits and gets zero-extended on the way to the register
    typedef struct packed {
        cop_op_t    op;
        reg_addr_t  addr;
        logic [8:0] imm;
    } cop_write_word_t;

    // One program word, the op field lines up in both views
    typedef union packed {
        cop_wait_t       wait_view;
        cop_write_word_t write_view;
    } cop_word_u;

endpackage

`default_nettype wire

/* hw/vdp_bus_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Structs carried between the host interface, copper, register file and
// raster counter. Compile after vdp_reg_pkg.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package vdp_bus_pkg;

    // 16-bit bus uses bits 4..0 as the index
    // 8-bit bus uses bits 5..1 as the index and bit 0 as the byte select
    typedef logic [5:0] host_addr_t;

    // Merged write stream into the register file
    typedef struct packed {
        logic                  en;
        vdp_reg_pkg::reg_addr_t addr;
        vdp_reg_pkg::reg_data_t data;
    } reg_write_t;

    // Copper request towards the host interface
    typedef struct packed {
        logic                  en;
        vdp_reg_pkg::reg_addr_t addr;
        vdp_reg_pkg::reg_data_t data;
    } cop_write_t;

    typedef struct packed {
        vdp_reg_pkg::line_t line;
        logic               frame_start;
    } raster_t;

endpackage

`default_nettype wire

/* hw/vdp_host_interface.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Host side of the VDP register block. Merges host and copper writes into
// one stream with host priority, gates host writes on VRAM activity and
// generates the delayed read address and the ready level.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module vdp_host_interface #(
    parameter int USE_8BIT_BUS = 0
) (
    input  wire                          clk,
    input  wire                          reset,

    input  wire vdp_bus_pkg::host_addr_t host_address,
    input  wire                          host_write_en,
    input  wire                          host_read_en,
    input  wire                          vram_write_pending,
    input  wire vdp_reg_pkg::reg_data_t  host_write_data,

    input  wire vdp_bus_pkg::cop_write_t cop_write,

    output vdp_bus_pkg::reg_write_t      reg_write,
    output vdp_reg_pkg::reg_addr_t       read_address,
    output logic                         ready
);

    vdp_bus_pkg::host_addr_t host_address_r;
    vdp_reg_pkg::reg_data_t  host_write_data_r;
    logic                    host_read_en_r;
    logic                    host_write_accept;
    logic                    host_write_accept_r;
    logic                    pending;
    logic [7:0]              low_byte;

    logic                    reg_write_en;
    vdp_reg_pkg::reg_addr_t  reg_write_addr;
    vdp_reg_pkg::reg_data_t  reg_write_data;

    // Host write only goes through with VRAM idle and the last write released
    assign host_write_accept = host_write_en && !vram_write_pending && !pending;

    always_ff @(posedge clk) begin
        host_address_r    <= host_address;
        host_write_data_r <= host_write_data;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            host_read_en_r      <= 1'b0;
            host_write_accept_r <= 1'b0;
            pending             <= 1'b0;
            ready               <= 1'b0;
        end else begin
            host_read_en_r      <= host_read_en;
            host_write_accept_r <= host_write_accept;

            // Writes are acknowledged at once, reads need one extra cycle
            ready <= host_write_accept || (host_read_en_r && host_read_en);

            // Stays set until the host drops its strobe
            if (pending && !host_write_en) begin
                pending <= 1'b0;
            end else if (host_write_accept) begin
                pending <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            reg_write_en <= 1'b0;
        end else if (USE_8BIT_BUS != 0) begin
            // Only the odd byte issues a write, copper is not merged here
            reg_write_en <= host_write_accept_r && host_address_r[0];
        end else begin
            reg_write_en <= host_write_accept || cop_write.en;
        end
    end

    always_ff @(posedge clk) begin
        if (USE_8BIT_BUS != 0) begin
            if (host_write_accept_r) begin
                if (host_address_r[0]) begin
                    reg_write_addr <= host_address_r[5:1];
                    reg_write_data <= {host_write_data_r[7:0], low_byte};
                end else begin
                    low_byte <= host_write_data_r[7:0];
                end
            end
            read_address <= host_address_r[5:1];
        end else begin
            // Host wins over the copper
            if (host_write_accept) begin
                reg_write_addr <= host_address[4:0];
                reg_write_data <= host_write_data;
            end else begin
                reg_write_addr <= cop_write.addr;
                reg_write_data <= cop_write.data;
            end
            read_address <= host_address_r[4:0];
        end
    end

    assign reg_write = '{en: reg_write_en, addr: reg_write_addr, data: reg_write_data};

    // A copper write in the same cycle as a host write would be lost
    a_no_write_conflict: assert property (@(posedge clk) disable iff (reset)
        !((USE_8BIT_BUS == 0) && host_write_accept && cop_write.en))
        else $error("host / copper write conflict, host %h, copper %h",
                    host_address, cop_write.addr);

endmodule

`default_nettype wire

/* hw/vdp_copper.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Copper coprocessor. Holds a small program loaded by the host and runs it
// once per frame, waiting on raster lines and writing VDP registers.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module vdp_copper #(
    parameter int PROGRAM_DEPTH = 16
) (
    input  wire                                 clk,
    input  wire                                 reset,

    input  wire                                 load_en,
    input  wire logic [$clog2(PROGRAM_DEPTH)-1:0] load_addr,
    input  wire vdp_reg_pkg::cop_word_u         load_data,

    input  wire vdp_reg_pkg::control_t          control,
    input  wire vdp_bus_pkg::raster_t           raster,

    output vdp_bus_pkg::cop_write_t             cop_write
);

    localparam int PC_W = $clog2(PROGRAM_DEPTH);

    vdp_reg_pkg::cop_word_u program_mem [PROGRAM_DEPTH];

    logic [PC_W-1:0]        pc;
    logic                   running;
    vdp_reg_pkg::cop_word_u word;
    logic                   last_slot;
    logic                   advance;
    logic                   stop;

    assign word      = program_mem[pc];
    assign last_slot = (pc == PC_W'(PROGRAM_DEPTH - 1));

    always_ff @(posedge clk) begin
        if (load_en) begin
            program_mem[load_addr] <= load_data;
        end
    end

    // Decode, both views share the op field
    always_comb begin
        advance = 1'b0;
        stop    = 1'b0;
        case (word.wait_view.op)
            vdp_reg_pkg::COP_WAIT:  advance = (raster.line == word.wait_view.target_line);
            vdp_reg_pkg::COP_WRITE: advance = 1'b1;
            default:                stop    = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            running   <= 1'b0;
            pc        <= '0;
            cop_write <= '0;
        end else begin
            cop_write.en <= 1'b0;

            if (raster.frame_start && control.copper_enable) begin
                pc      <= '0;
                running <= 1'b1;
            end else if (running) begin
                if (!control.copper_enable || stop) begin
                    running <= 1'b0;
                end else if (advance) begin
                    if (word.write_view.op == vdp_reg_pkg::COP_WRITE) begin
                        cop_write.en   <= 1'b1;
                        cop_write.addr <= word.write_view.addr;
                        cop_write.data <= {7'b0, word.write_view.imm};
                    end
                    // Falling off the end of memory acts like COP_END
                    if (last_slot) begin
                        running <= 1'b0;
                    end else begin
                        pc <= pc + 1'b1;
                    end
                end
            end
        end
    end

    // The fourth opcode encoding is never loaded into a running program
    a_legal_opcode: assert property (@(posedge clk) disable iff (reset)
        running |-> (word.wait_view.op != 2'b11))
        else $error("copper fetched unused opcode at pc %0d", pc);

endmodule

`default_nettype wire

/* hw/vdp_register_file.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// The 32 VDP registers. Written from the merged write stream, read
// combinationally by the host and decoded into control fields.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module vdp_register_file (
    input  wire                          clk,
    input  wire                          reset,

    input  wire vdp_bus_pkg::reg_write_t reg_write,

    input  wire vdp_reg_pkg::reg_addr_t  read_address,
    output vdp_reg_pkg::reg_data_t       read_data,

    output vdp_reg_pkg::control_t        control
);

    vdp_reg_pkg::reg_data_t regs [vdp_reg_pkg::REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < vdp_reg_pkg::REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_write.en) begin
            regs[reg_write.addr] <= reg_write.data;
        end
    end

    // Host read port, address already delayed by the host interface
    assign read_data = regs[read_address];

    assign control = vdp_reg_pkg::control_t'(regs[vdp_reg_pkg::REG_CONTROL]);

endmodule

`default_nettype wire

/* hw/vdp_raster_counter.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pixel and line counters. Gives the current line and a frame start pulse
// to the copper and to the top level.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module vdp_raster_counter #(
    parameter int H_TOTAL = 8,
    parameter int V_TOTAL = 12
) (
    input  wire                  clk,
    input  wire                  reset,
    output vdp_bus_pkg::raster_t raster
);

    localparam int PIX_W = (H_TOTAL > 1) ? $clog2(H_TOTAL) : 1;

    logic [PIX_W-1:0] pixel;

    always_ff @(posedge clk) begin
        if (reset) begin
            pixel  <= '0;
            raster <= '0;
        end else begin
            raster.frame_start <= 1'b0;
            if (pixel == PIX_W'(H_TOTAL - 1)) begin
                pixel <= '0;
                if (raster.line == vdp_reg_pkg::line_t'(V_TOTAL - 1)) begin
                    raster.line        <= '0;
                    raster.frame_start <= 1'b1;   // both counters back at 0
                end else begin
                    raster.line <= raster.line + 1'b1;
                end
            end else begin
                pixel <= pixel + 1'b1;
            end
        end
    end

    a_line_in_range: assert property (@(posedge clk) disable iff (reset)
        raster.line < V_TOTAL)
        else $error("raster line %0d out of range", raster.line);

endmodule

`default_nettype wire

/* hw/vdp_regs_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Top of the VDP register front end. Wires host interface, copper, register
// file and raster counter together and sets their parameters.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module vdp_regs_top #(
    parameter int USE_8BIT_BUS  = 0,
    parameter int PROGRAM_DEPTH = 16,
    parameter int H_TOTAL       = 8,
    parameter int V_TOTAL       = 12
) (
    input  wire                                   clk,
    input  wire                                   reset,

    input  wire vdp_bus_pkg::host_addr_t          host_address,
    input  wire                                   host_write_en,
    input  wire vdp_reg_pkg::reg_data_t           host_write_data,
    input  wire                                   host_read_en,
    input  wire                                   vram_write_pending,

    input  wire                                   cop_load_en,
    input  wire logic [$clog2(PROGRAM_DEPTH)-1:0] cop_load_addr,
    input  wire vdp_reg_pkg::cop_word_u           cop_load_data,

    output logic                                  ready,
    output vdp_reg_pkg::reg_data_t                host_read_data,
    output vdp_bus_pkg::raster_t                  raster
);

    vdp_bus_pkg::cop_write_t cop_write;
    vdp_bus_pkg::reg_write_t reg_write;
    vdp_reg_pkg::reg_addr_t  read_address;
    vdp_reg_pkg::control_t   control;

    vdp_host_interface #(
        .USE_8BIT_BUS(USE_8BIT_BUS)
    ) vdp_host_interface_inst (
        .clk               (clk),
        .reset             (reset),
        .host_address      (host_address),
        .host_write_en     (host_write_en),
        .host_read_en      (host_read_en),
        .vram_write_pending(vram_write_pending),
        .host_write_data   (host_write_data),
        .cop_write         (cop_write),
        .reg_write         (reg_write),
        .read_address      (read_address),
        .ready             (ready)
    );

    vdp_copper #(
        .PROGRAM_DEPTH(PROGRAM_DEPTH)
    ) vdp_copper_inst (
        .clk      (clk),
        .reset    (reset),
        .load_en  (cop_load_en),
        .load_addr(cop_load_addr),
        .load_data(cop_load_data),
        .control  (control),
        .raster   (raster),
        .cop_write(cop_write)
    );

    vdp_register_file vdp_register_file_inst (
        .clk         (clk),
        .reset       (reset),
        .reg_write   (reg_write),
        .read_address(read_address),
        .read_data   (host_read_data),
        .control     (control)
    );

    vdp_raster_counter #(
        .H_TOTAL(H_TOTAL),
        .V_TOTAL(V_TOTAL)
    ) vdp_raster_counter_inst (
        .clk   (clk),
        .reset (reset),
        .raster(raster)
    );

endmodule

`default_nettype wire

/* verif/vdp_regs_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed testbench for the VDP register front end. Runs host writes and
// reads, VRAM gating, a held write strobe, raster timing and a copper
// program, and checks the results against a model of the 32 registers.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module vdp_regs_tb;

    localparam int CLK_PERIOD    = 100;
    localparam int PROGRAM_DEPTH = 16;
    localparam int H_TOTAL       = 8;
    localparam int V_TOTAL       = 12;
    localparam int FRAME_CYCLES  = H_TOTAL * V_TOTAL;
    // Cycles for reset, 32 writes and reads, gating, held strobe and 5 frames
    localparam int TEST_CYCLES   = 8 + 64 * 6 + 40 + 40 + 5 * FRAME_CYCLES;

    logic                             clk;
    logic                             reset;
    vdp_bus_pkg::host_addr_t          host_address;
    logic                             host_write_en;
    vdp_reg_pkg::reg_data_t           host_write_data;
    logic                             host_read_en;
    logic                             vram_write_pending;
    logic                             cop_load_en;
    logic [$clog2(PROGRAM_DEPTH)-1:0] cop_load_addr;
    vdp_reg_pkg::cop_word_u           cop_load_data;
    logic                             ready;
    vdp_reg_pkg::reg_data_t           host_read_data;
    vdp_bus_pkg::raster_t             raster;

    vdp_reg_pkg::reg_data_t model [vdp_reg_pkg::REG_COUNT];
    logic [31:0]            rand_state;
    int                     error_count;
    int                     check_count;
    int                     test_count;
    int                     test_start_errors;

    vdp_regs_top #(
        .USE_8BIT_BUS (0),
        .PROGRAM_DEPTH(PROGRAM_DEPTH),
        .H_TOTAL      (H_TOTAL),
        .V_TOTAL      (V_TOTAL)
    ) vdp_regs_top_inst (
        .clk               (clk),
        .reset             (reset),
        .host_address      (host_address),
        .host_write_en     (host_write_en),
        .host_write_data   (host_write_data),
        .host_read_en      (host_read_en),
        .vram_write_pending(vram_write_pending),
        .cop_load_en       (cop_load_en),
        .cop_load_addr     (cop_load_addr),
        .cop_load_data     (cop_load_data),
        .ready             (ready),
        .host_read_data    (host_read_data),
        .raster            (raster)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin : watchdog
        #(TEST_CYCLES * 2 * CLK_PERIOD + 100 * CLK_PERIOD);
        $display("Watchdog expired at %0t ns, the tests did not finish in time", $time);
        $display("Simulation failed");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic vdp_reg_pkg::reg_data_t random_word();
        rand_state = xorshift32(rand_state);
        return rand_state[15:0];
    endfunction

    task automatic compare_data(input string what, input vdp_reg_pkg::reg_data_t actual,
                                input vdp_reg_pkg::reg_data_t expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("** Error at %0t ns: %s read %h, expected %h", $time, what, actual,
                     expected);
        end
    endtask

    task automatic compare_raster(input string what, input vdp_bus_pkg::raster_t actual,
                                  input vdp_bus_pkg::raster_t expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("** Error at %0t ns: %s line %0d start %b, expected line %0d start %b",
                     $time, what, actual.line, actual.frame_start, expected.line,
                     expected.frame_start);
        end
    endtask

    task automatic compare_count(input string what, input int actual, input int expected);
        check_count++;
        if (actual != expected) begin
            error_count++;
            $display("** Error at %0t ns: %s is %0d, expected %0d", $time, what, actual,
                     expected);
        end
    endtask

    task automatic compare_flag(input string what, input logic actual, input logic expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("** Error at %0t ns: %s is %b, expected %b", $time, what, actual,
                     expected);
        end
    endtask

    // All host tasks start and end on a falling edge
    task automatic host_write(input vdp_reg_pkg::reg_addr_t addr,
                              input vdp_reg_pkg::reg_data_t data);
        host_address    = {1'b0, addr};
        host_write_data = data;
        host_write_en   = 1'b1;
        @(negedge clk);
        while (!ready) begin
            @(negedge clk);
        end
        host_write_en = 1'b0;
        @(negedge clk);
        model[addr] = data;
    endtask

    task automatic host_read(input vdp_reg_pkg::reg_addr_t addr,
                             output vdp_reg_pkg::reg_data_t data);
        host_address = {1'b0, addr};
        host_read_en = 1'b1;
        @(negedge clk);
        while (!ready) begin
            @(negedge clk);
        end
        data         = host_read_data;
        host_read_en = 1'b0;
        @(negedge clk);
    endtask

    task automatic read_and_check(input vdp_reg_pkg::reg_addr_t addr);
        vdp_reg_pkg::reg_data_t data;
        host_read(addr, data);
        compare_data($sformatf("register %0d", addr), data, model[addr]);
    endtask

    task automatic load_word(input logic [$clog2(PROGRAM_DEPTH)-1:0] slot,
                             input vdp_reg_pkg::cop_word_u word);
        cop_load_en   = 1'b1;
        cop_load_addr = slot;
        cop_load_data = word;
        @(negedge clk);
        cop_load_en = 1'b0;
    endtask

    task automatic wait_frame_start();
        @(negedge clk);
        while (!raster.frame_start) begin
            @(negedge clk);
        end
    endtask

    task automatic start_test();
        test_start_errors = error_count;
    endtask

    task automatic end_test(input string name);
        test_count++;
        if (error_count == test_start_errors) begin
            $display("[%0t ns] test %s: ok", $time, name);
        end else begin
            $display("[%0t ns] test %s: FAILED with %0d errors", $time, name,
                     error_count - test_start_errors);
        end
    endtask

    task automatic test_write_read();
        vdp_reg_pkg::reg_data_t data;
        start_test();
        for (int i = 0; i < vdp_reg_pkg::REG_COUNT; i++) begin
            data = random_word();
            // Copper stays idle until the copper test
            if (5'(i) == vdp_reg_pkg::REG_CONTROL) begin
                data[0] = 1'b0;
            end
            host_write(5'(i), data);
        end
        for (int i = 0; i < vdp_reg_pkg::REG_COUNT; i++) begin
            read_and_check(5'(i));
        end
        end_test("write_read");
    endtask

    task automatic test_vram_gating();
        vdp_reg_pkg::reg_data_t data;
        start_test();
        data               = random_word();
        vram_write_pending = 1'b1;
        host_address       = 6'd7;
        host_write_data    = data;
        host_write_en      = 1'b1;
        repeat (6) begin
            @(negedge clk);
            compare_flag("ready with VRAM write pending", ready, 1'b0);
        end
        vram_write_pending = 1'b0;
        host_write(5'd7, data);
        read_and_check(5'd7);
        end_test("vram_gating");
    endtask

    task automatic test_held_strobe();
        vdp_reg_pkg::reg_data_t first;
        start_test();
        first           = random_word();
        host_address    = 6'd12;
        host_write_data = first;
        host_write_en   = 1'b1;
        @(negedge clk);
        while (!ready) begin
            @(negedge clk);
        end
        // New data under a held strobe must not be written
        host_write_data = ~first;
        repeat (5) @(negedge clk);
        host_write_en = 1'b0;
        @(negedge clk);
        model[12] = first;
        read_and_check(5'd12);
        host_write(5'd12, random_word());
        read_and_check(5'd12);
        end_test("held_strobe");
    endtask

    task automatic test_raster();
        vdp_bus_pkg::raster_t expected;
        int                   cycles;
        start_test();
        expected.line        = '0;
        expected.frame_start = 1'b1;
        wait_frame_start();
        compare_raster("raster at frame start", raster, expected);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!raster.frame_start);
        compare_count("cycles per frame", cycles, FRAME_CYCLES);
        end_test("raster");
    endtask

    task automatic test_copper();
        vdp_reg_pkg::cop_word_u word;
        start_test();
        word                       = '0;
        word.wait_view.op          = vdp_reg_pkg::COP_WAIT;
        word.wait_view.target_line = 14'd3;
        load_word(0, word);
        word                 = '0;
        word.write_view.op   = vdp_reg_pkg::COP_WRITE;
        word.write_view.addr = vdp_reg_pkg::REG_SCROLL_X;
        word.write_view.imm  = 9'h1A5;
        load_word(1, word);
        word              = '0;
        word.wait_view.op = vdp_reg_pkg::COP_END;
        load_word(2, word);
        host_write(vdp_reg_pkg::REG_CONTROL, 16'h0001);
        wait_frame_start();
        // By line 4 the write from line 3 has reached the register
        while (raster.line != 14'd4) begin
            @(negedge clk);
        end
        model[vdp_reg_pkg::REG_SCROLL_X] = 16'h01A5;
        read_and_check(vdp_reg_pkg::REG_SCROLL_X);
        read_and_check(vdp_reg_pkg::REG_CONTROL);
        end_test("copper");
    endtask

    initial begin
        clk                = 1'b0;
        reset              = 1'b1;
        host_address       = '0;
        host_write_en      = 1'b0;
        host_write_data    = '0;
        host_read_en       = 1'b0;
        vram_write_pending = 1'b0;
        cop_load_en        = 1'b0;
        cop_load_addr      = '0;
        cop_load_data      = '0;
        rand_state         = 32'ha449_ab89;
        error_count        = 0;
        check_count        = 0;
        test_count         = 0;
        for (int i = 0; i < vdp_reg_pkg::REG_COUNT; i++) begin
            model[i] = '0;
        end

        repeat (8) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        test_write_read();
        test_vram_gating();
        test_held_strobe();
        test_raster();
        test_copper();

        $display("Tests run %0d, checks %0d, errors %0d", test_count, check_count,
                 error_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vdp_regs.f */
hw/vdp_reg_pkg.sv
hw/vdp_bus_pkg.sv
hw/vdp_host_interface.sv
hw/vdp_copper.sv
hw/vdp_register_file.sv
hw/vdp_raster_counter.sv
hw/vdp_regs_top.sv
verif/vdp_regs_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -eo pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
    --top-module vdp_regs_tb -f vdp_regs.f

sim_output=$(./obj_dir/Vvdp_regs_tb | tee /dev/stderr)

if grep -qx "Simulation completed successfully" <<< "$sim_output"; then
    exit 0
fi
exit 1
